//--- tb.f
source/wb_bus_pkg.sv
source/wb_map_pkg.sv
source/wb_mem_dly.sv
source/wb_bank_decode.sv
source/wb_resp_merge.sv
source/wb_mem_banks.sv
verif/wb_bank_props.sv
verif/wb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top \
    -f tb.f -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
exit 1

//--- verif/tb_top.sv
`timescale 1ns/10ps

module tb_top
    import wb_bus_pkg::*;
    import wb_map_pkg::*;
;

    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_WADDR_W-1:0] wb_addr;
    logic [WB_DATA_W-1:0]  wb_wdata;
    logic [WB_SEL_W-1:0]   wb_sel;
    logic                  wb_stall;
    logic                  wb_ack;
    logic [WB_DATA_W-1:0]  wb_rdata;

    integer seed;
    int     pass_cnt;
    int     fail_cnt;
    int     err_base;

    wb_mem_banks #(
        .NUM_BANKS (4),
        .STALL_WS  (2),
        .ACK_WS    (1)
    ) wb_mem_banks_i (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_wdata),
        .i_wb_sel   (wb_sel),
        .o_wb_stall (wb_stall),
        .o_wb_ack   (wb_ack),
        .o_wb_data  (wb_rdata)
    );

    wb_checker wb_checker_i (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_wdata),
        .i_wb_sel   (wb_sel),
        .i_wb_stall (wb_stall),
        .i_wb_ack   (wb_ack),
        .i_wb_rdata (wb_rdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    // Called on a rising edge; returns on the edge that accepts the request
    task automatic issue_req(input logic we_v, input logic [WB_WADDR_W-1:0] a,
                             input logic [WB_DATA_W-1:0] d, input logic [WB_SEL_W-1:0] s);
        int waited;
        waited = 0;
        wb_stb   <= 1'b1;
        wb_we    <= we_v;
        wb_addr  <= a;
        wb_wdata <= d;
        wb_sel   <= s;
        @(negedge clk);
        while (wb_stall && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_stall) begin
            abort_on_timeout("stall to be released");
        end
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        wb_stb <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic begin_test();
        @(posedge clk);
        err_base = wb_checker_i.err_cnt;
        wb_cyc <= 1'b1;
    endtask

    // Wait for all acks, close the cycle and report
    task automatic end_test(input string name);
        int waited;
        waited = 0;
        wb_stb <= 1'b0;
        @(negedge clk);
        while (wb_checker_i.acc_cnt != wb_checker_i.ack_cnt && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_checker_i.acc_cnt != wb_checker_i.ack_cnt) begin
            abort_on_timeout("outstanding acks");
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        @(posedge clk);
        if (wb_checker_i.err_cnt == err_base) begin
            $display("Test %s passed", name);
            pass_cnt++;
        end else begin
            $display("Test %s failed with %0d errors", name, wb_checker_i.err_cnt - err_base);
            fail_cnt++;
        end
    endtask

    initial begin
        wb_waddr_u            ad;
        logic [31:0]          r;
        logic [31:0]          d;
        logic [WB_WADDR_W-1:0] addrs [16];

        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_addr  = '0;
        wb_wdata = '0;
        wb_sel   = '0;
        seed     = 32'h1a6f_d5ae;
        pass_cnt = 0;
        fail_cnt = 0;
        err_base = 0;

        repeat (2) @(posedge clk);
        // Bus cycle opens as reset releases, with no strobe yet
        rst    <= 1'b0;
        wb_cyc <= 1'b1;
        repeat (2) @(posedge clk);

        begin_test();
        for (int i = 0; i < 16; i++) begin
            r = rand_word();
            issue_req(1'b0, r[7:0], '0, WB_SEL_FULL);
        end
        end_test("reset_contents");

        // Four words in each bank, written then read back
        begin_test();
        for (int i = 0; i < 16; i++) begin
            r = rand_word();
            d = rand_word();
            ad.split.bank = 2'(i % 4);
            ad.split.ofs  = r[5:0];
            addrs[i] = ad.flat;
            issue_req(1'b1, addrs[i], d, WB_SEL_FULL);
        end
        for (int i = 0; i < 16; i++) begin
            issue_req(1'b0, addrs[i], '0, WB_SEL_FULL);
        end
        end_test("full_word");

        begin_test();
        for (int i = 0; i < 16; i++) begin
            r = rand_word();
            d = rand_word();
            issue_req(1'b1, r[7:0], d, WB_SEL_FULL);
            d = rand_word();
            issue_req(1'b1, r[7:0], d, r[11:8]);
            issue_req(1'b0, r[7:0], '0, WB_SEL_FULL);
        end
        end_test("byte_lanes");

        // Alternating banks forces the decoder to hold each switch
        begin_test();
        for (int i = 0; i < 24; i++) begin
            r = rand_word();
            ad.split.bank = 2'(i % 4);
            ad.split.ofs  = r[5:0];
            issue_req(1'b0, ad.flat, '0, WB_SEL_FULL);
        end
        end_test("pipelined_reads");

        begin_test();
        for (int i = 0; i < 300; i++) begin
            r = rand_word();
            d = rand_word();
            issue_req(r[12], r[7:0], d, r[11:8]);
            if (r[15:14] != 2'd0) begin
                idle_cycles(int'(r[17:16]));
            end
        end
        end_test("random_traffic");

        $display("Tests passed %0d, failed %0d, checker errors %0d",
                 pass_cnt, fail_cnt, wb_checker_i.err_cnt);
        if (fail_cnt == 0 && wb_checker_i.err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verif/wb_checker.sv
`timescale 1ns/10ps

module wb_checker
    import wb_bus_pkg::*;
    import wb_map_pkg::*;
(
    input logic                 i_clk,
    input logic                 i_rst,
    input logic                 i_wb_cyc,
    input logic                 i_wb_stb,
    input logic                 i_wb_we,
    input wb_waddr_u            i_wb_addr,
    input logic [WB_DATA_W-1:0] i_wb_data,
    input logic [WB_SEL_W-1:0]  i_wb_sel,
    input logic                 i_wb_stall,
    input logic                 i_wb_ack,
    input logic [WB_DATA_W-1:0] i_wb_rdata
);

    localparam int MODEL_WORDS = 1 << WB_WADDR_W;

    logic [WB_DATA_W-1:0] model [MODEL_WORDS];

    // Upper bit marks a read, the rest is the expected data
    logic [WB_DATA_W:0] expect_q [$];

    int err_cnt;
    int acc_cnt;
    int ack_cnt;

    initial begin
        for (int w = 0; w < MODEL_WORDS; w++) begin
            model[w] = '0;
        end
        err_cnt = 0;
        acc_cnt = 0;
        ack_cnt = 0;
    end

    always @(posedge i_clk) begin
        logic [WB_DATA_W:0] entry;
        if (!i_rst) begin
            // Acks always belong to earlier requests, so handle them first
            if (i_wb_ack) begin
                ack_cnt++;
                if (expect_q.size() == 0) begin
                    $display("Ack arrived with no request outstanding");
                    err_cnt++;
                end else begin
                    entry = expect_q.pop_front();
                    if (entry[WB_DATA_W] && i_wb_rdata !== entry[WB_DATA_W-1:0]) begin
                        $display("Mismatch: o_wb_data expected %h actual %h",
                                 entry[WB_DATA_W-1:0], i_wb_rdata);
                        err_cnt++;
                    end
                end
            end
            if (i_wb_cyc && i_wb_stb && !i_wb_stall) begin
                acc_cnt++;
                if (i_wb_we) begin
                    for (int lane = 0; lane < WB_SEL_W; lane++) begin
                        if (i_wb_sel[lane]) begin
                            model[i_wb_addr.flat][lane*WB_BYTE_W +: WB_BYTE_W] =
                                i_wb_data[lane*WB_BYTE_W +: WB_BYTE_W];
                        end
                    end
                    expect_q.push_back({1'b0, {WB_DATA_W{1'b0}}});
                end else begin
                    expect_q.push_back({1'b1, model[i_wb_addr.flat]});
                end
            end
        end
    end

endmodule

//--- verif/wb_bank_props.sv
`timescale 1ns/10ps

module wb_bank_props (
    input logic i_clk,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic o_wb_stall,
    input logic o_wb_ack
);

    // An ack only follows a cycle that was already open
    ack_needs_cyc: assert property (@(posedge i_clk)
        o_wb_ack |-> (i_wb_cyc && $past(i_wb_cyc)))
        else $error("bank ack seen without an open cycle");

    ack_single: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_wb_ack && !(i_wb_cyc && i_wb_stb && !o_wb_stall)) |=> !o_wb_ack)
        else $error("bank ack held for two cycles without a new request");

    quiet_after_reset: assert property (@(posedge i_clk) i_rst |=> (!o_wb_stall && !o_wb_ack))
        else $error("bank stall or ack high right after reset");

endmodule

bind wb_mem_dly wb_bank_props wb_bank_props_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .o_wb_stall (o_wb_stall),
    .o_wb_ack   (o_wb_ack)
);

//--- source/wb_mem_banks.sv
`timescale 1ns/10ps

module wb_mem_banks
    import wb_bus_pkg::*;
    import wb_map_pkg::*;
#(
    parameter int NUM_BANKS = 4,
    parameter int STALL_WS  = 2,
    parameter int ACK_WS    = 1
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [WB_WADDR_W-1:0] i_wb_addr,
    input  logic [WB_DATA_W-1:0]  i_wb_data,
    input  logic [WB_SEL_W-1:0]   i_wb_sel,
    output logic                  o_wb_stall,
    output logic                  o_wb_ack,
    output logic [WB_DATA_W-1:0]  o_wb_data
);

    logic [NUM_BANKS-1:0]                bank_stb;
    logic [NUM_BANKS-1:0]                bank_stall;
    logic [NUM_BANKS-1:0]                bank_ack;
    logic [NUM_BANKS-1:0][WB_DATA_W-1:0] bank_data;
    logic [BANK_OFS_W-1:0]               bank_ofs;

    wb_bank_decode #(
        .NUM_BANKS (NUM_BANKS)
    ) wb_bank_decode_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_addr    (i_wb_addr),
        .i_bank_stall (bank_stall),
        .i_bank_ack   (bank_ack),
        .o_wb_stall   (o_wb_stall),
        .o_bank_stb   (bank_stb),
        .o_bank_ofs   (bank_ofs)
    );

    // cyc, we, data and sel are shared by every bank
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        wb_mem_dly #(
            .STALL_WS (STALL_WS),
            .ACK_WS   (ACK_WS)
        ) wb_mem_dly_i (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_wb_cyc   (i_wb_cyc),
            .i_wb_stb   (bank_stb[b]),
            .i_wb_we    (i_wb_we),
            .i_wb_addr  (bank_ofs),
            .i_wb_data  (i_wb_data),
            .i_wb_sel   (i_wb_sel),
            .o_wb_stall (bank_stall[b]),
            .o_wb_ack   (bank_ack[b]),
            .o_wb_data  (bank_data[b])
        );
    end

    wb_resp_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) wb_resp_merge_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_wb_cyc    (i_wb_cyc),
        .i_bank_ack  (bank_ack),
        .i_bank_data (bank_data),
        .o_wb_ack    (o_wb_ack),
        .o_wb_data   (o_wb_data)
    );

endmodule

//--- source/wb_resp_merge.sv
`timescale 1ns/10ps

module wb_resp_merge
    import wb_bus_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_wb_cyc,
    input  logic [NUM_BANKS-1:0]                i_bank_ack,
    input  logic [NUM_BANKS-1:0][WB_DATA_W-1:0] i_bank_data,
    output logic                                o_wb_ack,
    output logic [WB_DATA_W-1:0]                o_wb_data
);

    logic                 ack_any;
    logic [WB_DATA_W-1:0] ack_data;
    logic                 r_ack;
    logic [WB_DATA_W-1:0] r_data;

    assign ack_any = |i_bank_ack;

    // Only one bank acks at a time, so an AND-OR select is enough
    always_comb begin
        ack_data = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (i_bank_ack[b]) begin
                ack_data = ack_data | i_bank_data[b];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || !i_wb_cyc) begin
            r_ack <= 1'b0;
        end else begin
            r_ack <= ack_any;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ack_any) begin
            r_data <= ack_data;
        end
    end

    assign o_wb_ack  = r_ack;
    assign o_wb_data = r_data;

endmodule

//--- source/wb_bank_decode.sv
`timescale 1ns/10ps

module wb_bank_decode
    import wb_map_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  wb_waddr_u             i_wb_addr,
    input  logic [NUM_BANKS-1:0]  i_bank_stall,
    input  logic [NUM_BANKS-1:0]  i_bank_ack,
    output logic                  o_wb_stall,
    output logic [NUM_BANKS-1:0]  o_bank_stb,
    output logic [BANK_OFS_W-1:0] o_bank_ofs
);

    logic [1:0]            out_cnt;
    logic [BANK_IDX_W-1:0] owner;
    logic [BANK_IDX_W-1:0] sel_bank;
    logic                  hold;
    logic                  accept;
    logic                  ack_any;

    // Indices past the last bank alias onto the low banks
    assign sel_bank = BANK_IDX_W'(i_wb_addr.split.bank % NUM_BANKS);
    assign o_bank_ofs = i_wb_addr.split.ofs;

    // Another bank may not start until the owner has answered everything
    assign hold = (out_cnt != 2'd0) && (sel_bank != owner);

    assign o_wb_stall = i_bank_stall[sel_bank] || hold;
    assign accept     = i_wb_cyc && i_wb_stb && !o_wb_stall;
    assign ack_any    = |i_bank_ack;

    always_comb begin
        o_bank_stb = '0;
        if (i_wb_stb && !hold) begin
            o_bank_stb[sel_bank] = 1'b1;
        end
    end

    // Requests accepted but not yet acked by a bank
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_wb_cyc) begin
            out_cnt <= 2'd0;
        end else begin
            out_cnt <= out_cnt + 2'(accept) - 2'(ack_any);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner <= '0;
        end else if (accept) begin
            owner <= sel_bank;
        end
    end

endmodule

//--- source/wb_mem_dly.sv
`timescale 1ns/10ps

module wb_mem_dly
    import wb_bus_pkg::*;
    import wb_map_pkg::*;
#(
    parameter int STALL_WS = 2,
    parameter int ACK_WS   = 1
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [BANK_OFS_W-1:0] i_wb_addr,
    input  logic [WB_DATA_W-1:0]  i_wb_data,
    input  logic [WB_SEL_W-1:0]   i_wb_sel,
    output logic                  o_wb_stall,
    output logic                  o_wb_ack,
    output logic [WB_DATA_W-1:0]  o_wb_data
);

    localparam int MEM_WORDS = 1 << BANK_OFS_W;

    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_STALL_WAIT = 2'd1;
    localparam logic [1:0] ST_ACK_WAIT   = 2'd2;
    localparam logic [1:0] ST_ACK        = 2'd3;

    // Counter preload, one less than the wait count
    localparam logic [7:0] STALL_LOAD = (STALL_WS > 0) ? 8'(STALL_WS - 1) : 8'd0;
    localparam logic [7:0] ACK_LOAD   = (ACK_WS > 0) ? 8'(ACK_WS - 1) : 8'd0;

    // Where a request goes next, skipping zero-length waits
    localparam logic [1:0] ST_RESP = (ACK_WS > 0) ? ST_ACK_WAIT : ST_ACK;
    localparam logic [1:0] ST_REQ  = (STALL_WS > 0) ? ST_STALL_WAIT : ST_RESP;

    logic [1:0]            state;
    logic [1:0]            state_next;
    logic [7:0]            stall_ctr;
    logic [7:0]            ack_ctr;
    logic                  accept;

    logic [BANK_OFS_W-1:0] r_addr;
    logic                  r_we;
    logic [WB_DATA_W-1:0]  r_data;
    logic [WB_SEL_W-1:0]   r_sel;

    logic [WB_DATA_W-1:0]  mem [MEM_WORDS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_wb_stb) begin
                    state_next = ST_REQ;
                end
            end
            ST_STALL_WAIT: begin
                if (stall_ctr == 8'd0) begin
                    state_next = ST_RESP;
                end
            end
            ST_ACK_WAIT: begin
                if (ack_ctr == 8'd0) begin
                    state_next = ST_ACK;
                end
            end
            default: begin
                // Back-to-back request taken in the ack cycle
                state_next = i_wb_stb ? ST_REQ : ST_IDLE;
            end
        endcase
        if (!i_wb_cyc) begin
            state_next = ST_IDLE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stall_ctr <= 8'd0;
        end else if (state != ST_STALL_WAIT && state_next == ST_STALL_WAIT) begin
            stall_ctr <= STALL_LOAD;
        end else if (stall_ctr != 8'd0) begin
            stall_ctr <= stall_ctr - 8'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_ctr <= 8'd0;
        end else if (state != ST_ACK_WAIT && state_next == ST_ACK_WAIT) begin
            ack_ctr <= ACK_LOAD;
        end else if (ack_ctr != 8'd0) begin
            ack_ctr <= ack_ctr - 8'd1;
        end
    end

    // Busy while waiting to ack, otherwise only the stall wait holds off
    assign o_wb_stall = i_wb_cyc && (state_next == ST_STALL_WAIT || state == ST_ACK_WAIT);
    assign o_wb_ack   = i_wb_cyc && (state == ST_ACK);
    assign accept     = i_wb_cyc && i_wb_stb && !o_wb_stall;

    // Request held until its ack cycle
    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_addr <= i_wb_addr;
            r_we   <= i_wb_we;
            r_data <= i_wb_data;
            r_sel  <= i_wb_sel;
        end
    end

    // Banks start out cleared
    initial begin
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem[w] = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_wb_ack && r_we) begin
            for (int lane = 0; lane < WB_SEL_W; lane++) begin
                if (r_sel[lane]) begin
                    mem[r_addr][lane*WB_BYTE_W +: WB_BYTE_W] <=
                        r_data[lane*WB_BYTE_W +: WB_BYTE_W];
                end
            end
        end
    end

    // Zero outside a read ack
    always_comb begin
        o_wb_data = '0;
        if (o_wb_ack && !r_we) begin
            o_wb_data = mem[r_addr];
        end
    end

endmodule

//--- source/wb_map_pkg.sv
package wb_map_pkg;

    // Bank select field, upper bits of the word address
    localparam int BANK_IDX_W = 2;

    // Word offset inside one bank
    localparam int BANK_OFS_W = 6;

    // Full word address seen on the master port
    localparam int WB_WADDR_W = BANK_IDX_W + BANK_OFS_W;

    typedef struct packed {
        logic [BANK_IDX_W-1:0] bank;
        logic [BANK_OFS_W-1:0] ofs;
    } wb_bank_addr_s;

    // Same word read either as a flat index or as bank plus offset
    typedef union packed {
        logic [WB_WADDR_W-1:0] flat;
        wb_bank_addr_s         split;
    } wb_waddr_u;

endpackage

//--- source/wb_bus_pkg.sv
package wb_bus_pkg;

    // Data bus width
    localparam int WB_DATA_W = 32;

    // One select bit per byte lane
    localparam int WB_SEL_W = 4;

    // Bits carried by a single lane
    localparam int WB_BYTE_W = WB_DATA_W / WB_SEL_W;

    // All lanes enabled, full-word access
    localparam logic [WB_SEL_W-1:0] WB_SEL_FULL = '1;

endpackage
